// File: common/dcx_pkg.sv
`default_nettype none

package dcx_pkg;

    // One RGB888 pixel, red in the top byte.
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // A rebuilt pixel and its place in the active window.
    typedef struct packed {
        logic        valid;
        pixel_t      pixel;
        logic [11:0] x;
        logic [11:0] y;
        logic        frame_start;
    } capture_t;

    // Write port of the frame buffer.
    typedef struct packed {
        logic        wren;
        logic [15:0] wraddr;
        pixel_t      wrdata;
    } ram_write_t;

    // Output video, syncs and enable active high.
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        pixel_t rgb;
    } video_out_t;

    // Which beat of a pixel pair comes next.
    typedef enum logic {
        PHASE_FIRST,
        PHASE_SECOND
    } capture_phase_e;

    // Output side, idle until a full frame is stored.
    typedef enum logic {
        OUT_IDLE,
        OUT_RUN
    } output_state_e;

endpackage

`default_nettype wire

// File: hw/video_capture.sv
`default_nettype none

module video_capture import dcx_pkg::*; #(
    parameter int H_ACTIVE = 16,
    parameter int V_ACTIVE = 8,
    parameter int H_BACK   = 4
) (
    input  wire        clock,
    input  wire        arst_n,
    input  wire        hsync_n,
    input  wire        vsync_n,
    input  wire [11:0] data,
    input  wire        line_doubler,
    output capture_t   cap
);

    logic           hsync_q;
    logic           vsync_q;
    logic           line_on;
    logic [11:0]    porch_cnt;
    capture_phase_e phase;
    logic [11:0]    x_cnt;
    logic [11:0]    y_cnt;
    logic           valid_q;
    logic           start_q;
    logic [11:0]    first_beat;
    pixel_t         pixel_q;
    logic [11:0]    x_q;
    logic [11:0]    y_q;
    logic           hs_rise;
    logic           vs_fall;
    logic           beat_active;
    logic           pair_done;
    logic [11:0]    v_lines;
    logic           in_window;

    assign hs_rise     = hsync_n & ~hsync_q;
    assign vs_fall     = ~vsync_n & vsync_q;
    // The edge beat is beat zero of the back porch.
    assign beat_active = line_on && !hs_rise && (porch_cnt == 12'(H_BACK));
    assign pair_done   = beat_active && (phase == PHASE_SECOND);
    assign v_lines     = line_doubler ? 12'(V_ACTIVE / 2) : 12'(V_ACTIVE);
    assign in_window   = (y_cnt < v_lines);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
            line_on   <= 1'b0;
            porch_cnt <= '0;
            phase     <= PHASE_FIRST;
            x_cnt     <= '0;
            y_cnt     <= '0;
            valid_q   <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            hsync_q <= hsync_n;
            vsync_q <= vsync_n;
            valid_q <= pair_done && in_window;
            start_q <= pair_done && in_window && (x_cnt == '0) && (y_cnt == '0);
            if (hs_rise) begin
                line_on   <= 1'b1;
                porch_cnt <= 12'd1;
                phase     <= PHASE_FIRST;
                x_cnt     <= '0;
            end else if (line_on) begin
                if (porch_cnt != 12'(H_BACK)) begin
                    porch_cnt <= porch_cnt + 12'd1;
                end else if (phase == PHASE_FIRST) begin
                    phase <= PHASE_SECOND;
                end else begin
                    phase <= PHASE_FIRST;
                    if (x_cnt == 12'(H_ACTIVE - 1)) begin
                        line_on <= 1'b0;
                        if (in_window) begin
                            y_cnt <= y_cnt + 12'd1;
                        end
                    end else begin
                        x_cnt <= x_cnt + 12'd1;
                    end
                end
            end
            // Frame start wins over the line step.
            if (vs_fall) begin
                y_cnt <= '0;
            end
        end
    end

    // Beat one is red and green high nibble, beat two green low nibble and blue.
    always_ff @(posedge clock) begin
        if (beat_active && (phase == PHASE_FIRST)) begin
            first_beat <= data;
        end
        if (pair_done) begin
            pixel_q <= {first_beat, data};
            x_q     <= x_cnt;
            y_q     <= y_cnt;
        end
    end

    assign cap = '{valid: valid_q, pixel: pixel_q, x: x_q, y: y_q, frame_start: start_q};

endmodule

`default_nettype wire

// File: hw/video2ram.sv
`default_nettype none

module video2ram import dcx_pkg::*; #(
    parameter int H_ACTIVE = 16,
    parameter int V_ACTIVE = 8
) (
    input  wire         clock,
    input  wire         arst_n,
    input  wire         line_doubler,
    input  wire capture_t cap,
    output ram_write_t  wr,
    output logic        frame_ready
);

    logic [11:0] last_y;
    logic        last_pixel;
    logic        wren_q;
    logic        last_q;
    logic [15:0] addr_q;
    pixel_t      data_q;

    // Half as many stored lines when doubling.
    assign last_y     = line_doubler ? 12'(V_ACTIVE / 2 - 1) : 12'(V_ACTIVE - 1);
    assign last_pixel = cap.valid && (cap.x == 12'(H_ACTIVE - 1)) && (cap.y == last_y);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wren_q      <= 1'b0;
            last_q      <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            wren_q      <= cap.valid;
            last_q      <= last_pixel;
            frame_ready <= wren_q && last_q;
        end
    end

    // Row major layout.
    always_ff @(posedge clock) begin
        if (cap.valid) begin
            addr_q <= 16'(cap.y * H_ACTIVE + cap.x);
            data_q <= cap.pixel;
        end
    end

    assign wr = '{wren: wren_q, wraddr: addr_q, wrdata: data_q};

endmodule

`default_nettype wire

// File: hw/video_buffer.sv
`default_nettype none

module video_buffer import dcx_pkg::*; #(
    parameter int H_ACTIVE  = 16,
    parameter int V_ACTIVE  = 8,
    parameter int ADDR_BITS = 7
) (
    input  wire                  clock,
    input  wire ram_write_t      wr,
    input  wire [ADDR_BITS-1:0]  rdaddr,
    output pixel_t               rddata
);

    localparam int DEPTH = H_ACTIVE * V_ACTIVE;

    pixel_t mem [DEPTH];

    // Read before write on the same address.
    always_ff @(posedge clock) begin
        if (wr.wren) begin
            mem[wr.wraddr[ADDR_BITS-1:0]] <= wr.wrdata;
        end
        rddata <= mem[rdaddr];
    end

endmodule

`default_nettype wire

// File: hw/ram2video.sv
`default_nettype none

module ram2video import dcx_pkg::*; #(
    parameter int H_ACTIVE  = 16,
    parameter int V_ACTIVE  = 8,
    parameter int H_TOTAL   = 24,
    parameter int H_SYNC    = 2,
    parameter int V_TOTAL   = 12,
    parameter int V_SYNC    = 2,
    parameter int ADDR_BITS = 7
) (
    input  wire                  clock,
    input  wire                  arst_n,
    input  wire                  ready,
    input  wire                  frame_ready,
    input  wire                  line_doubler,
    input  wire pixel_t          rddata,
    output logic [ADDR_BITS-1:0] rdaddr,
    output video_out_t           out
);

    output_state_e state;
    logic [11:0]   h_cnt;
    logic [11:0]   v_cnt;
    logic          run;
    logic          h_wrap;
    logic          v_wrap;
    logic          de0;
    logic          hs0;
    logic          vs0;
    logic [11:0]   row;
    logic          de1;
    logic          hs1;
    logic          vs1;

    assign run    = (state == OUT_RUN);
    assign h_wrap = (h_cnt == 12'(H_TOTAL - 1));
    assign v_wrap = (v_cnt == 12'(V_TOTAL - 1));

    // Timing decoded straight from the counters.
    assign de0 = run && (h_cnt < 12'(H_ACTIVE)) && (v_cnt < 12'(V_ACTIVE));
    assign hs0 = run && (h_cnt < 12'(H_SYNC));
    assign vs0 = run && (v_cnt >= 12'(V_TOTAL - V_SYNC));

    // Each stored row is shown twice when doubling.
    assign row    = line_doubler ? {1'b0, v_cnt[11:1]} : v_cnt;
    assign rdaddr = de0 ? ADDR_BITS'(row * H_ACTIVE + h_cnt) : '0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= OUT_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                OUT_IDLE: begin
                    if (ready && frame_ready) begin
                        state <= OUT_RUN;
                    end
                end
                OUT_RUN: begin
                    if (h_wrap) begin
                        h_cnt <= '0;
                        v_cnt <= v_wrap ? 12'd0 : v_cnt + 12'd1;
                    end else begin
                        h_cnt <= h_cnt + 12'd1;
                    end
                end
                default: begin
                    state <= OUT_IDLE;
                end
            endcase
        end
    end

    // Stage one waits for the buffer read, stage two is the output register.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            de1 <= 1'b0;
            hs1 <= 1'b0;
            vs1 <= 1'b0;
            out <= '0;
        end else begin
            de1       <= de0;
            hs1       <= hs0;
            vs1       <= vs0;
            out.hsync <= hs1;
            out.vsync <= vs1;
            out.de    <= de1;
            out.rgb   <= de1 ? rddata : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/startup_delay.sv
`default_nettype none

module startup_delay #(
    parameter int STARTUP_CYCLES = 32
) (
    input  wire  clock,
    input  wire  arst_n,
    output logic ready
);

    localparam int CNT_BITS = $clog2(STARTUP_CYCLES + 1);

    logic [CNT_BITS-1:0] cnt;

    // Saturates once ready is set.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            if (cnt == CNT_BITS'(STARTUP_CYCLES - 1)) begin
                ready <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dcx_top.sv
`default_nettype none

module dcx_top import dcx_pkg::*; #(
    parameter int H_ACTIVE       = 16,
    parameter int V_ACTIVE       = 8,
    parameter int H_BACK         = 4,
    parameter int H_TOTAL        = 24,
    parameter int H_SYNC         = 2,
    parameter int V_TOTAL        = 12,
    parameter int V_SYNC         = 2,
    parameter int ADDR_BITS      = 7,
    parameter int STARTUP_CYCLES = 32
) (
    input  wire        clock,
    input  wire        arst_n,
    input  wire        hsync_n,
    input  wire        vsync_n,
    input  wire [11:0] data,
    input  wire        line_doubler,
    output video_out_t out,
    output logic       ready
);

    capture_t             cap;
    ram_write_t           wr;
    logic                 frame_ready;
    logic [ADDR_BITS-1:0] rdaddr;
    pixel_t               rddata;

    video_capture #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_BACK(H_BACK)
    ) video_input (
        .clock(clock),
        .arst_n(arst_n),
        .hsync_n(hsync_n),
        .vsync_n(vsync_n),
        .data(data),
        .line_doubler(line_doubler),
        .cap(cap)
    );

    video2ram #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) video2ram (
        .clock(clock),
        .arst_n(arst_n),
        .line_doubler(line_doubler),
        .cap(cap),
        .wr(wr),
        .frame_ready(frame_ready)
    );

    video_buffer #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .ADDR_BITS(ADDR_BITS)
    ) video_buffer (
        .clock(clock),
        .wr(wr),
        .rdaddr(rdaddr),
        .rddata(rddata)
    );

    ram2video #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_TOTAL(H_TOTAL),
        .H_SYNC(H_SYNC),
        .V_TOTAL(V_TOTAL),
        .V_SYNC(V_SYNC),
        .ADDR_BITS(ADDR_BITS)
    ) ram2video (
        .clock(clock),
        .arst_n(arst_n),
        .ready(ready),
        .frame_ready(frame_ready),
        .line_doubler(line_doubler),
        .rddata(rddata),
        .rdaddr(rdaddr),
        .out(out)
    );

    startup_delay #(
        .STARTUP_CYCLES(STARTUP_CYCLES)
    ) output_startup_delay (
        .clock(clock),
        .arst_n(arst_n),
        .ready(ready)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clock
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period.
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

endmodule

`default_nettype wire

// File: sim/tb_dcx.sv
`default_nettype none

module tb_dcx import dcx_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACTIVE       = 16;
    localparam int V_ACTIVE       = 8;
    localparam int H_BACK         = 4;
    localparam int H_TOTAL        = 24;
    localparam int H_SYNC         = 2;
    localparam int V_TOTAL        = 12;
    localparam int V_SYNC         = 2;
    localparam int ADDR_BITS      = 7;
    localparam int STARTUP_CYCLES = 32;
    localparam int PIXELS         = H_ACTIVE * V_ACTIVE;
    localparam int SAMPLES        = 2 * H_TOTAL * V_TOTAL;
    localparam int LIMIT          = 4000;

    logic        clock;
    logic        arst_n;
    logic        hsync_n;
    logic        vsync_n;
    logic [11:0] data;
    logic        line_doubler;
    video_out_t  out;
    logic        ready;
    logic [31:0] rng_state;
    pixel_t      ref_frame [PIXELS];
    video_out_t  samples [SAMPLES];
    int          test_errors [1:6];
    bit          sending;
    bit          timed_out;

    tb_clock clock_gen (.clock(clock));

    dcx_top #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_BACK(H_BACK),
        .H_TOTAL(H_TOTAL),
        .H_SYNC(H_SYNC),
        .V_TOTAL(V_TOTAL),
        .V_SYNC(V_SYNC),
        .ADDR_BITS(ADDR_BITS),
        .STARTUP_CYCLES(STARTUP_CYCLES)
    ) dcx_top_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic record_mismatch(input int test_id, input string msg);
        test_errors[test_id]++;
        $display("Mismatch at %0d ns: %s", $time, msg);
    endtask

    task automatic record_failure(input int test_id, input string msg);
        test_errors[test_id]++;
        $display("Error: %s", msg);
    endtask

    task automatic flag_timeout(input string what);
        timed_out = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic report_test(input int id, input string name);
        if (test_errors[id] == 0) begin
            $display("Test %0d, %s: ok", id, name);
        end else begin
            $display("Test %0d, %s: %0d errors", id, name, test_errors[id]);
        end
    endtask

    task automatic drive_beat(input logic hs_n, input logic vs_n, input logic [11:0] beat);
        @(posedge clock);
        hsync_n <= hs_n;
        vsync_n <= vs_n;
        data    <= beat;
    endtask

    task automatic fill_reference(input int lines);
        for (int i = 0; i < lines * H_ACTIVE; i++) begin
            rng_state    = xorshift32(rng_state);
            ref_frame[i] = rng_state[23:0];
        end
    endtask

    // Vsync pulse, then per line an hsync pulse, back porch, beat pairs and two idle beats.
    task automatic send_frame(input int lines);
        pixel_t px;
        repeat (8) drive_beat(1'b0, 1'b0, 12'h000);
        for (int y = 0; y < lines; y++) begin
            repeat (4) drive_beat(1'b0, 1'b1, 12'h000);
            for (int b = 0; b < H_BACK + 2 * H_ACTIVE + 2; b++) begin
                if (b < H_BACK || b >= H_BACK + 2 * H_ACTIVE) begin
                    drive_beat(1'b1, 1'b1, 12'h000);
                end else begin
                    px = ref_frame[y * H_ACTIVE + (b - H_BACK) / 2];
                    if ((b - H_BACK) % 2 == 0) begin
                        drive_beat(1'b1, 1'b1, {px.red, px.green[7:4]});
                    end else begin
                        drive_beat(1'b1, 1'b1, {px.green[3:0], px.blue});
                    end
                end
            end
        end
    endtask

    task automatic apply_reset(input bit doubled, input bit check);
        int n;
        @(posedge clock);
        arst_n       <= 1'b0;
        line_doubler <= doubled;
        for (int i = 0; i < 16; i++) begin
            @(negedge clock);
            if (check) begin
                assert (!ready && out == '0) else record_mismatch(1,
                    $sformatf("ready %0b out %07h during reset", ready, out));
            end
            @(posedge clock);
        end
        arst_n <= 1'b1;
        n = 0;
        @(negedge clock);
        while (!ready && n < LIMIT) begin
            if (check) begin
                assert (out == '0) else record_mismatch(1,
                    $sformatf("out %07h before ready", out));
            end
            @(posedge clock);
            n++;
            @(negedge clock);
        end
        if (!ready) begin
            flag_timeout("ready after reset");
        end else if (check) begin
            assert (n == STARTUP_CYCLES) else record_mismatch(1,
                $sformatf("ready rose after %0d cycles, expected %0d", n, STARTUP_CYCLES));
        end
    endtask

    // Two output frames from the first de; pixels and blanking are checked live.
    task automatic capture_output(input int test_id, input bit doubled);
        int     n;
        int     k;
        int     line;
        pixel_t expected;
        n = 0;
        k = 0;
        @(negedge clock);
        while (!out.de && n < LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!out.de) begin
            flag_timeout("the first output pixel");
            return;
        end
        for (int i = 0; i < SAMPLES; i++) begin
            if (i > 0) @(negedge clock);
            samples[i] = out;
            if (out.de && k < PIXELS) begin
                line     = k / H_ACTIVE;
                expected = ref_frame[(doubled ? line / 2 : line) * H_ACTIVE + k % H_ACTIVE];
                assert (out.rgb == expected) else record_mismatch(test_id,
                    $sformatf("line %0d pixel %0d rgb %06h expected %06h",
                        line, k % H_ACTIVE, out.rgb, expected));
                k++;
            end else if (!out.de) begin
                assert (out.rgb == '0) else record_mismatch(6,
                    $sformatf("rgb %06h while de is low", out.rgb));
            end
        end
        if (k < PIXELS) begin
            record_failure(test_id, $sformatf("only %0d of %0d pixels were shown", k, PIXELS));
        end
    endtask

    task automatic check_geometry();
        int run_len;
        int last_hs;
        int lines;
        int vs_edges [$];
        run_len = 0;
        last_hs = -1;
        for (int i = 0; i < SAMPLES; i++) begin
            if (samples[i].de) run_len++;
            if ((!samples[i].de || i == SAMPLES - 1) && run_len != 0) begin
                assert (run_len == H_ACTIVE) else record_mismatch(3,
                    $sformatf("de run of %0d cycles ending at sample %0d", run_len, i));
                run_len = 0;
            end
            if (i > 0 && samples[i].hsync && !samples[i - 1].hsync) begin
                if (last_hs >= 0) begin
                    assert (i - last_hs == H_TOTAL) else record_mismatch(3,
                        $sformatf("hsync period %0d, expected %0d", i - last_hs, H_TOTAL));
                end
                last_hs = i;
            end
            if (i > 0 && samples[i].vsync && !samples[i - 1].vsync) vs_edges.push_back(i);
        end
        if (last_hs < 0) record_failure(3, "no rising edge of hsync in two output frames");
        if (vs_edges.size() < 2) begin
            record_failure(3, "fewer than two vsync pulses in two output frames");
        end else begin
            lines = 0;
            for (int i = vs_edges[0]; i < vs_edges[1]; i++) begin
                if (samples[i].de && !samples[i - 1].de) lines++;
            end
            assert (lines == V_ACTIVE) else record_mismatch(3,
                $sformatf("%0d active lines between vsync pulses", lines));
        end
    endtask

    // Stops early once a wait has run out of time.
    task automatic run_tests();
        apply_reset(1'b0, 1'b1);
        report_test(1, "reset state");
        if (timed_out) return;
        fill_reference(V_ACTIVE);
        sending = 1'b1;
        fork
            begin
                send_frame(V_ACTIVE);
                sending = 1'b0;
            end
            while (sending) begin
                @(negedge clock);
                assert (!out.de) else record_mismatch(2, "de high before the frame was stored");
            end
        join
        report_test(2, "no output before a frame");
        capture_output(4, 1'b0);
        if (timed_out) return;
        check_geometry();
        report_test(3, "output geometry");
        report_test(4, "pixel content");

        apply_reset(1'b1, 1'b0);
        if (timed_out) return;
        fill_reference(V_ACTIVE / 2);
        send_frame(V_ACTIVE / 2);
        capture_output(5, 1'b1);
        if (timed_out) return;
        report_test(5, "line doubler");
        report_test(6, "blanking");
    endtask

    initial begin
        int failed_tests;
        int total_errors;
        arst_n       = 1'b0;
        hsync_n      = 1'b1;
        vsync_n      = 1'b1;
        data         = 12'h000;
        line_doubler = 1'b0;
        rng_state    = 32'hbe0721fc;
        sending      = 1'b0;
        timed_out    = 1'b0;
        failed_tests = 0;
        total_errors = 0;
        for (int i = 1; i <= 6; i++) test_errors[i] = 0;

        run_tests();

        for (int i = 1; i <= 6; i++) begin
            if (test_errors[i] != 0) failed_tests++;
            total_errors += test_errors[i];
        end
        $display("Tests: 6, failed: %0d, errors: %0d", failed_tests, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
common/dcx_pkg.sv
hw/video_capture.sv
hw/video2ram.sv
hw/video_buffer.sv
hw/ram2video.sv
hw/startup_delay.sv
hw/dcx_top.sv
sim/tb_clock.sv
sim/tb_dcx.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP      = tb_dcx
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
